// ==== Bender.yml ====
package:
  name: ebus

sources:
  - include_dirs:
      - source
    files:
      - source/apbPkg.sv
      - source/ebusPkg.sv
      - source/ebusApbPort.sv
      - source/edp.sv
      - source/irUnit.sv
      - source/scd.sv
      - source/ebusMux.sv
      - source/ebusTop.sv

  - target: test
    include_dirs:
      - source
    files:
      - verif/ebusTb.sv

// ==== files.f ====
+incdir+source
source/apbPkg.sv
source/ebusPkg.sv
source/ebusApbPort.sv
source/edp.sv
source/irUnit.sv
source/scd.sv
source/ebusMux.sv
source/ebusTop.sv
verif/ebusTb.sv

// ==== source/apbPkg.sv ====
`default_nettype none

`include "ebus_settings.svh"

package apbPkg;

  // Bus field widths
  typedef logic [`APB_ADDR_W-1:0] tApbAddr;   // Byte offset into the window
  typedef logic [`APB_DATA_W-1:0] tApbData;   // One data beat

  // Host to slave, held stable from setup until PREADY
  typedef struct packed {
    logic    psel;                             // Slave selected
    logic    penable;                          // Access phase
    logic    pwrite;                           // 1 write, 0 read
    tApbAddr paddr;                            // Register offset
    tApbData pwdata;                           // Low word of an operand
  } tApbReq;

  // Slave to host
  typedef struct packed {
    logic    pready;                           // Access completes this cycle
    tApbData prdata;                           // Read data, valid with PREADY
    logic    pslverr;                          // Bad offset or write-only read
  } tApbRsp;

endpackage

`default_nettype wire

// ==== source/ebusApbPort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_settings.svh"

module ebusApbPort (
  input  logic            eboxClk,
  input  logic            arstN,
  input  apbPkg::tApbReq  apbReq,
  output apbPkg::tApbRsp  apbRsp,
  output ebusPkg::tSrcCmd srcCmd,
  input  ebusPkg::tEbus   ebusCapt
);

  localparam int HI_W = `EBUS_WORD_W - `APB_DATA_W;  // Bits above the APB word

  ebusPkg::tPortState state, stateNext;
  logic [HI_W-1:0]    hiNibble;                // Staged word bits 35..32
  logic setup, access, wrStrobe;
  logic isAr, isHi, isArAdd, isIr, isSc, isScSub;
  logic srcRead, errAcc;

  assign setup  = apbReq.psel & ~apbReq.penable;
  assign access = apbReq.psel & apbReq.penable;

  // Offset decode
  assign isAr    = apbReq.paddr == `REG_AR;
  assign isHi    = apbReq.paddr == `REG_HI;
  assign isArAdd = apbReq.paddr == `REG_ARADD;
  assign isIr    = apbReq.paddr == `REG_IR;
  assign isSc    = apbReq.paddr == `REG_SC;
  assign isScSub = apbReq.paddr == `REG_SCSUB;

  assign srcRead = ~apbReq.pwrite & (isAr | isIr | isSc);  // Needs the EBUS
  assign errAcc  = ~(isAr | isHi | isArAdd | isIr | isSc | isScSub) |
                   (~apbReq.pwrite & (isArAdd | isScSub)); // Unmapped or write-only

  // Writes always finish in IDLE on the first access cycle
  assign wrStrobe = access & apbReq.pwrite & (state == ebusPkg::IDLE);

  always_comb begin
    stateNext = state;
    case (state)
      ebusPkg::IDLE:  if (setup && srcRead) stateNext = ebusPkg::DRIVE;  // Arm for the bus cycle
      ebusPkg::DRIVE: if (access) stateNext = ebusPkg::REPLY;            // Mux captures here
      ebusPkg::REPLY: stateNext = ebusPkg::IDLE;
      default:        stateNext = ebusPkg::IDLE;
    endcase
  end

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      state    <= ebusPkg::IDLE;
      hiNibble <= '0;
    end else begin
      state <= stateNext;
      if (wrStrobe && isHi) hiNibble <= apbReq.pwdata[HI_W-1:0];  // Kept until next REG_HI write
    end
  end

  // Source commands
  always_comb begin
    srcCmd             = '0;
    srcCmd.operand     = {hiNibble, apbReq.pwdata};
    srcCmd.loadAr      = wrStrobe & isAr;
    srcCmd.addAr       = wrStrobe & isArAdd;
    srcCmd.loadIr      = wrStrobe & isIr;
    srcCmd.loadSc      = wrStrobe & isSc;
    srcCmd.subSc       = wrStrobe & isScSub;
    srcCmd.drivers.edp = (state == ebusPkg::DRIVE) & isAr;  // One flag per read
    srcCmd.drivers.ir  = (state == ebusPkg::DRIVE) & isIr;
    srcCmd.drivers.scd = (state == ebusPkg::DRIVE) & isSc;
  end

  // Response
  always_comb begin
    apbRsp = '0;
    case (state)
      ebusPkg::IDLE: begin
        if (access && !srcRead) begin          // Writes, REG_HI and error reads
          apbRsp.pready  = 1'b1;
          apbRsp.pslverr = errAcc;
          if (isHi && !apbReq.pwrite)
            apbRsp.prdata = apbPkg::tApbData'({ebusCapt.parity,
                                               ebusCapt.data[`EBUS_WORD_W-1:`APB_DATA_W]});
        end
      end
      ebusPkg::REPLY: begin
        apbRsp.pready = 1'b1;
        apbRsp.prdata = ebusCapt.data[`APB_DATA_W-1:0];  // Low word of the capture
      end
      default: apbRsp = '0;                    // DRIVE is the wait state
    endcase
  end

  readyInAccess: assert property (@(posedge eboxClk) disable iff (!arstN)
    apbRsp.pready |-> apbReq.psel && apbReq.penable)
    else $error("PREADY raised outside an APB access phase");

  // The mux must have taken the word during DRIVE
  replyHasCapture: assert property (@(posedge eboxClk) disable iff (!arstN)
    state == ebusPkg::REPLY |-> ebusCapt.valid)
    else $error("Read reply without a fresh EBUS capture");

endmodule

`default_nettype wire

// ==== source/ebusMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebusMux (
  input  logic          eboxClk,
  input  logic          arstN,
  input  ebusPkg::tWord edpEbus,
  input  ebusPkg::tWord irEbus,
  input  ebusPkg::tWord scdEbus,
  input  logic          edpDrive,
  input  logic          irDrive,
  input  logic          scdDrive,
  output ebusPkg::tEbus ebusCapt
);

  ebusPkg::tWord selWord;                      // Word on the bus this cycle
  logic          anyDrive;

  assign anyDrive = edpDrive | irDrive | scdDrive;

  // Priority EDP, IR, SCD
  always_comb begin
    if (edpDrive)      selWord = edpEbus;
    else if (irDrive)  selWord = irEbus;
    else if (scdDrive) selWord = scdEbus;
    else               selWord = '0;           // Idle bus reads zero
  end

  // Capture register
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      ebusCapt <= '0;
    end else begin
      ebusCapt.valid <= anyDrive;              // Fresh-capture strobe
      if (anyDrive) begin
        ebusCapt.data   <= selWord;
        ebusCapt.parity <= ~^selWord;          // Odd parity
      end
    end
  end

  // Sources follow the port's one-hot select
  oneDriver: assert property (@(posedge eboxClk) disable iff (!arstN)
    $onehot0({edpDrive, irDrive, scdDrive}))
    else $error("More than one EBUS driver raised");

endmodule

`default_nettype wire

// ==== source/ebusPkg.sv ====
`default_nettype none

`include "ebus_settings.svh"

package ebusPkg;

  // Datapath fields
  typedef logic [`EBUS_WORD_W-1:0] tWord;      // Full PDP-10 word
  typedef logic [8:0]              tOpcode;    // Instruction bits 0..8
  typedef logic [3:0]              tAcField;   // Instruction bits 9..12
  typedef logic [`SC_W-1:0]        tShiftCount;

  // One request per EBUS source, at most one raised
  typedef struct packed {
    logic edp;                                 // AR onto the bus
    logic ir;                                  // Opcode and AC onto the bus
    logic scd;                                 // Shift count onto the bus
  } tEbusDrivers;

  // Port to source commands, each a single-cycle pulse
  typedef struct packed {
    logic        loadAr;                       // AR <= operand
    logic        addAr;                        // AR <= AR + operand
    logic        loadIr;                       // IR <= operand
    logic        loadSc;                       // SC <= operand low bits
    logic        subSc;                        // SC <= SC - operand low bits
    tWord        operand;                      // Staged nibble and PWDATA
    tEbusDrivers drivers;                      // Read source select
  } tSrcCmd;

  // Captured bus word
  typedef struct packed {
    tWord data;                                // Last selected word
    logic parity;                              // Odd parity over data
    logic valid;                               // Capture taken last cycle
  } tEbus;

  // APB read sequencing
  typedef enum logic [1:0] {
    IDLE,                                      // Writes and one-cycle reads
    DRIVE,                                     // First access cycle of a source read
    REPLY                                      // Second access cycle, data returned
  } tPortState;

endpackage

`default_nettype wire

// ==== source/ebusTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebusTop (
  input  logic           eboxClk,
  input  logic           arstN,
  input  apbPkg::tApbReq apbReq,
  output apbPkg::tApbRsp apbRsp
);

  ebusPkg::tSrcCmd srcCmd;                     // Port to the three sources
  ebusPkg::tEbus   ebusCapt;                   // Mux back to the port
  ebusPkg::tWord   edpEbus, irEbus, scdEbus;
  logic            edpDrive, irDrive, scdDrive;

  // Input side
  ebusApbPort port0 (
    .eboxClk (eboxClk),
    .arstN   (arstN),
    .apbReq  (apbReq),
    .apbRsp  (apbRsp),
    .srcCmd  (srcCmd),
    .ebusCapt(ebusCapt)
  );

  // EBUS sources
  edp    edp0 (.eboxClk(eboxClk), .arstN(arstN), .srcCmd(srcCmd),
               .edpEbus(edpEbus), .edpDrive(edpDrive));
  irUnit ir0  (.eboxClk(eboxClk), .arstN(arstN), .srcCmd(srcCmd),
               .irEbus(irEbus), .irDrive(irDrive));
  scd    scd0 (.eboxClk(eboxClk), .arstN(arstN), .srcCmd(srcCmd),
               .scdEbus(scdEbus), .scdDrive(scdDrive));

  // Output side
  ebusMux mux0 (
    .eboxClk (eboxClk),
    .arstN   (arstN),
    .edpEbus (edpEbus),
    .irEbus  (irEbus),
    .scdEbus (scdEbus),
    .edpDrive(edpDrive),
    .irDrive (irDrive),
    .scdDrive(scdDrive),
    .ebusCapt(ebusCapt)
  );

endmodule

`default_nettype wire

// ==== source/ebus_settings.svh ====
`ifndef EBUS_SETTINGS_SVH
`define EBUS_SETTINGS_SVH

// Datapath widths
`define EBUS_WORD_W 36          // PDP-10 word, bits 0..35 map to 35..0 here
`define SC_W 10                 // SCD shift count

// Front-end APB
`define APB_ADDR_W 12           // 4 KB register window
`define APB_DATA_W 32           // Low word per access, high nibble staged

// Register offsets within the window
`define REG_AR 12'h000          // AR load, read via EDP
`define REG_HI 12'h004          // Staged nibble on write, capture nibble on read
`define REG_ARADD 12'h008       // AR add, write only
`define REG_IR 12'h00C          // IR load, read via IR
`define REG_SC 12'h010          // Shift count load, read via SCD
`define REG_SCSUB 12'h014       // Shift count subtract, write only

// Bit position of parity in an REG_HI read
`define HI_PAR_BIT 4

`endif

// ==== source/edp.sv ====
`timescale 1ns/1ps
`default_nettype none

module edp (
  input  logic            eboxClk,
  input  logic            arstN,
  input  ebusPkg::tSrcCmd srcCmd,
  output ebusPkg::tWord   edpEbus,
  output logic            edpDrive
);

  ebusPkg::tWord ar;                           // Arithmetic register
  ebusPkg::tWord arSum;                        // AR plus operand

  // Adder, carry out of bit 0 drops
  assign arSum = ar + srcCmd.operand;          // Modulo 2**36

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      ar <= '0;
    end else if (srcCmd.loadAr) begin
      ar <= srcCmd.operand;                    // Front-end load
    end else if (srcCmd.addAr) begin
      ar <= arSum;                             // Accumulate
    end
  end

  // EBUS side
  assign edpDrive = srcCmd.drivers.edp;        // Request the bus
  assign edpEbus  = edpDrive ? ar : '0;        // Quiet when not selected

endmodule

`default_nettype wire

// ==== source/irUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module irUnit (
  input  logic            eboxClk,
  input  logic            arstN,
  input  ebusPkg::tSrcCmd srcCmd,
  output ebusPkg::tWord   irEbus,
  output logic            irDrive
);

  ebusPkg::tWord    ir;                        // Whole instruction word
  ebusPkg::tOpcode  opcode;                    // PDP-10 bits 0..8
  ebusPkg::tAcField acField;                   // PDP-10 bits 9..12

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      ir <= '0;
    end else if (srcCmd.loadIr) begin
      ir <= srcCmd.operand;                    // Instruction fetch stand-in
    end
  end

  // Field split, PDP-10 bit 0 is the MSB
  assign opcode  = ir[35:27];
  assign acField = ir[26:23];

  // EBUS side
  assign irDrive = srcCmd.drivers.ir;
  assign irEbus  = irDrive ? ebusPkg::tWord'({opcode, acField}) : '0;  // Right-justified, zero fill

endmodule

`default_nettype wire

// ==== source/scd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_settings.svh"

module scd (
  input  logic            eboxClk,
  input  logic            arstN,
  input  ebusPkg::tSrcCmd srcCmd,
  output ebusPkg::tWord   scdEbus,
  output logic            scdDrive
);

  ebusPkg::tShiftCount sc;                     // Shift count register
  ebusPkg::tShiftCount scOperand;              // Operand low bits
  ebusPkg::tShiftCount scDiff;                 // SC minus operand

  assign scOperand = srcCmd.operand[`SC_W-1:0];
  assign scDiff    = sc - scOperand;           // Wraps modulo 1024

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      sc <= '0;
    end else if (srcCmd.loadSc) begin
      sc <= scOperand;
    end else if (srcCmd.subSc) begin
      sc <= scDiff;                            // Goes negative past zero
    end
  end

  // EBUS side, bit 9 is the sign
  assign scdDrive = srcCmd.drivers.scd;
  assign scdEbus  = scdDrive ? {{(`EBUS_WORD_W - `SC_W){sc[`SC_W-1]}}, sc} : '0;

endmodule

`default_nettype wire

// ==== verif/ebusTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ebus_settings.svh"

module ebusTb;

  localparam int    RandSeed   = 73;
  localparam int    ReadyLimit = 4;                // Access cycles before giving up
  localparam string VecFile    = "verif/ebus_tests.txt";

  logic           eboxClk;
  logic           arstN;
  apbPkg::tApbReq apbReq;
  apbPkg::tApbRsp apbRsp;

  int cycles;                                      // Rising edges so far
  int cycleLimit;                                  // Zero until vectors are counted
  int vecCount;
  int testNum;
  int errCount;                                    // Failed checks, all tests
  int passCount;
  int failCount;
  bit fileError;

  ebusTop dut (
    .eboxClk(eboxClk),
    .arstN  (arstN),
    .apbReq (apbReq),
    .apbRsp (apbRsp)
  );

  always #10 eboxClk = ~eboxClk;                   // 20 ns period

  // Watchdog
  always @(posedge eboxClk) begin
    cycles = cycles + 1;
    if (cycleLimit != 0 && cycles >= cycleLimit) begin
      $display("Timeout: run went past %0d clock cycles", cycleLimit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Next vector line, comment lines start with a lone #
  task automatic nextVector(input int fd, output logic found, output logic [63:0] op,
                            output logic [`APB_ADDR_W-1:0] addr,
                            output logic [31:0] data, output logic [31:0] check);
    logic [63:0]      tok;
    logic [8*120-1:0] rest;
    logic             atEnd;
    int               n;
    found = 1'b0;
    atEnd = 1'b0;
    op    = '0;
    addr  = '0;
    data  = '0;
    check = '0;
    while (!found && !atEnd) begin
      tok = '0;
      n = $fscanf(fd, " %s", tok);
      if (n != 1) begin
        atEnd = 1'b1;                              // End of file
      end else if (tok == "#") begin
        n = $fgets(rest, fd);                      // Drop comment text
      end else begin
        n = $fscanf(fd, " %h %h %h", addr, data, check);
        op = tok;
        if (n == 3) begin
          found = 1'b1;
        end else begin
          $display("Vector file has a malformed line after vector %0d", vecCount);
          fileError = 1'b1;
          atEnd = 1'b1;
        end
      end
    end
  endtask

  // One APB transfer, setup then access until PREADY
  task automatic apbAccess(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                           input logic [`APB_DATA_W-1:0] wdata,
                           output logic [`APB_DATA_W-1:0] rdata,
                           output logic slvErr, output logic ready, output int waits);
    @(negedge eboxClk);
    apbReq.psel    = 1'b1;                         // Setup phase
    apbReq.penable = 1'b0;
    apbReq.pwrite  = wr;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(negedge eboxClk);
    apbReq.penable = 1'b1;                         // Access phase
    waits = 0;
    #1;                                            // Response settled, edge far off
    while (!apbRsp.pready && waits < ReadyLimit) begin
      @(negedge eboxClk);
      #1;
      waits = waits + 1;                           // Wait state seen
    end
    ready  = apbRsp.pready;
    rdata  = apbRsp.prdata;
    slvErr = apbRsp.pslverr;
    @(negedge eboxClk);                            // Completing edge is behind us
    apbReq = '0;
  endtask

  initial begin : mainSeq
    logic [63:0]            op;
    logic [`APB_ADDR_W-1:0] addr;
    logic [31:0]            data, check, wdata, rdata;
    logic                   slvErr, ready, found, isRead, wantErr;
    int                     fd, waits, wantWaits, errsBefore;
    string                  opName;

    eboxClk   = 1'b0;
    arstN     = 1'b0;                              // Reset from time zero
    apbReq    = '0;
    cycles    = 0;
    cycleLimit = 0;
    vecCount  = 0;
    testNum   = 0;
    errCount  = 0;
    passCount = 0;
    failCount = 0;
    fileError = 1'b0;
    void'($urandom(RandSeed));

    // First pass sizes the watchdog
    fd = $fopen(VecFile, "r");
    if (fd == 0) begin
      $display("Cannot open the vector file %0s", VecFile);
      fileError = 1'b1;
    end else begin
      found = 1'b1;
      while (found) begin
        nextVector(fd, found, op, addr, data, check);
        if (found) vecCount = vecCount + 1;
      end
      $fclose(fd);
    end
    cycleLimit = 10 * vecCount + 50;

    repeat (4) @(negedge eboxClk);
    arstN = 1'b1;

    if (!fileError) begin
      fd = $fopen(VecFile, "r");
      found = 1'b1;
      while (found) begin
        nextVector(fd, found, op, addr, data, check);
        if (found) begin
          testNum    = testNum + 1;
          errsBefore = errCount;
          isRead     = (op == "r") || (op == "e");
          wantErr    = (op == "e");               // Write-only or unmapped read
          opName     = (op == "w") ? "write" : (op == "r") ? "read" : "error read";
          if (op != "w" && !isRead) begin
            $display("Test %0d has an unknown operation code", testNum);
            errCount = errCount + 1;
          end else begin
            // Care mask clear bits get random data
            wdata = isRead ? 32'h0 : ((data & check) | ($urandom() & ~check));
            // Source reads carry the one EBUS wait state
            wantWaits = (op == "r" && (addr == `REG_AR || addr == `REG_IR ||
                                       addr == `REG_SC)) ? 1 : 0;
            apbAccess(!isRead, addr, wdata, rdata, slvErr, ready, waits);
            if (!ready) begin
              $display("No PREADY within %0d access cycles for %0s of offset 0x%03h",
                       ReadyLimit, opName, addr);
              errCount = errCount + 1;
            end else begin
              if (waits != wantWaits) begin
                $display("FAILED at %0t: %0s 0x%03h took %0d wait states, expected %0d",
                         $time, opName, addr, waits, wantWaits);
                errCount = errCount + 1;
              end
              if (slvErr !== wantErr) begin
                $display("FAILED at %0t: %0s 0x%03h PSLVERR %b, expected %b",
                         $time, opName, addr, slvErr, wantErr);
                errCount = errCount + 1;
              end
              if (op == "r" && rdata !== check) begin
                $display("FAILED at %0t: read 0x%03h returned 0x%08h, expected 0x%08h",
                         $time, addr, rdata, check);
                errCount = errCount + 1;
              end
            end
          end
          if (errCount == errsBefore) begin
            passCount = passCount + 1;
            $display("Test %0d: %0s 0x%03h ok", testNum, opName, addr);
          end else begin
            failCount = failCount + 1;
            $display("Test %0d: %0s 0x%03h mismatch", testNum, opName, addr);
          end
        end
      end
      $fclose(fd);
    end

    $display("Summary: %0d tests, %0d passed, %0d failed", testNum, passCount, failCount);
    if (fileError || vecCount == 0 || failCount != 0) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/ebus_tests.txt ====
# Columns: op offset data check, hex; w check is a care mask, clear bits random
# r check is the expected PRDATA; e is a read that must return PSLVERR
# Reset state, zero word has odd parity bit set
r 000 00000000 00000000
r 004 00000000 00000010
# AR load 0x9_12345678 and readback
w 004 00000009 0000000f
w 000 12345678 ffffffff
r 000 00000000 12345678
r 004 00000000 00000009
# AR load 0x5_00000000, even weight
w 004 00000005 0000000f
w 000 00000000 ffffffff
r 000 00000000 00000000
r 004 00000000 00000015
# AR add wrapping past 2**36
w 004 0000000f 0000000f
w 000 fffffff0 ffffffff
w 004 00000000 0000000f
w 008 00000020 ffffffff
r 000 00000000 00000010
r 004 00000000 00000000
w 004 00000001 0000000f
w 008 00000000 ffffffff
r 000 00000000 00000010
r 004 00000000 00000011
# IR opcode 270 octal, AC 5
w 004 00000005 0000000f
w 00c c2801234 ffffffff
r 00c 00000000 00000b85
r 004 00000000 00000010
# IR all-ones opcode and AC
w 004 0000000f 0000000f
w 00c ff800000 ffffffff
r 00c 00000000 00001fff
r 004 00000000 00000000
# Shift count 5 minus 8 gives -3
w 010 00000005 000003ff
w 014 00000008 000003ff
r 010 00000000 fffffffd
r 004 00000000 0000000f
# Shift count 0x1f0 minus 0xf0
w 010 000001f0 000003ff
w 014 000000f0 000003ff
r 010 00000000 00000100
r 004 00000000 00000000
# Error reads leave AR alone
w 004 00000003 0000000f
w 000 cafef00d ffffffff
e 008 00000000 00000000
e 014 00000000 00000000
e 018 00000000 00000000
e 3fc 00000000 00000000
r 000 00000000 cafef00d
r 004 00000000 00000013
